/* hdl/aes_config.svh */
`ifndef AES_CONFIG_SVH
`define AES_CONFIG_SVH

// Width of one cipher block. A round key has the same width.
`define AES_BLOCK_BITS 128

// A 128-bit key is four 32-bit words.
`define AES_KEY_WORDS 4

// Number of cipher rounds for a 128-bit key.
`define AES_ROUNDS 10

// The first round constant, doubled once per round after it.
`define AES_RCON_INIT 8'h01

// Low byte of x^8 + x^4 + x^3 + x + 1, folded back in when doubling overflows.
`define AES_GF_POLY 8'h1b

`endif

/* hdl/aesPkg.sv */
`include "aes_config.svh"

package aesPkg;

	typedef logic [`AES_BLOCK_BITS-1:0] block_t;  // State, key or ciphertext.
	typedef logic [31:0] word_t;                  // One key-schedule word.
	typedef logic [7:0] byte_t;                   // One GF(2^8) element.

	// Per-cycle control sent from the controller to the key schedule and datapath.
	typedef struct packed {
		logic load;       // Take a new block and key this cycle.
		logic step;       // Run one round this cycle.
		logic lastRound;  // This is round 10, so MixColumns is skipped.
	} roundCtrl_t;

	typedef enum logic {
		Idle,
		Run
	} ctrlState_e;

	// Forward S-box, one table row of sixteen entries per line.
	// Entry 0 sits in the most significant byte.
	localparam logic [0:255][7:0] sboxTable = {
		128'h637c777bf26b6fc53001672bfed7ab76,
		128'hca82c97dfa5947f0add4a2af9ca472c0,
		128'hb7fd9326363ff7cc34a5e5f171d83115,
		128'h04c723c31896059a071280e2eb27b275,
		128'h09832c1a1b6e5aa0523bd6b329e32f84,
		128'h53d100ed20fcb15b6acbbe394a4c58cf,
		128'hd0efaafb434d338545f9027f503c9fa8,
		128'h51a3408f929d38f5bcb6da2110fff3d2,
		128'hcd0c13ec5f974417c4a77e3d645d1973,
		128'h60814fdc222a908846eeb814de5e0bdb,
		128'he0323a0a4906245cc2d3ac629195e479,
		128'he7c8376d8dd54ea96c56f4ea657aae08,
		128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
		128'h703eb5664803f60e613557b986c11d9e,
		128'he1f8981169d98e949b1e87e9ce5528df,
		128'h8ca1890dbfe6426841992d0fb054bb16
	};

	function automatic byte_t sboxLookup(input byte_t x);
		return sboxTable[x];
	endfunction

	// Multiply by 02 in GF(2^8). A carry out of bit 7 is reduced by the polynomial.
	function automatic byte_t gfDouble(input byte_t x);
		byte_t shifted;
		shifted = {x[6:0], 1'b0};
		return x[7] ? (shifted ^ `AES_GF_POLY) : shifted;
	endfunction

endpackage

/* hdl/aesControl.sv */
`timescale 1ns/10ps
`include "aes_config.svh"

module aesControl (
	input  logic               clk,
	input  logic               rstN,
	input  logic               start,
	output aesPkg::roundCtrl_t roundCtrl,
	output logic               done,
	output logic               busy
);

	localparam int cntBits = $clog2(`AES_ROUNDS + 1);

	aesPkg::ctrlState_e state;
	logic [cntBits-1:0] round;  // Number of the round being run, 1 to AES_ROUNDS.
	logic               running;
	logic               finalRound;

	assign running    = (state == aesPkg::Run);
	assign finalRound = running && (round == cntBits'(`AES_ROUNDS));

	// A start is only taken while idle. The done cycle is already idle, so a
	// start there chains the next block without a gap.
	always_comb begin
		roundCtrl.load      = start && (state == aesPkg::Idle);
		roundCtrl.step      = running;
		roundCtrl.lastRound = finalRound;
	end

	assign busy = running;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= aesPkg::Idle;
			round <= '0;
			done  <= 1'b0;
		end else begin
			done <= finalRound;  // Pulses on the edge that retires round 10.
			if (roundCtrl.load) begin
				state <= aesPkg::Run;
				round <= cntBits'(1);
			end else if (running) begin
				if (finalRound)
					state <= aesPkg::Idle;
				else
					round <= round + 1'b1;
			end
		end
	end

	doneOneCycle: assert property (@(posedge clk) disable iff (!rstN) done |=> !done);

	roundInRange: assert property (@(posedge clk) disable iff (!rstN)
		round <= cntBits'(`AES_ROUNDS));

	loadStepExclusive: assert property (@(posedge clk) disable iff (!rstN)
		!(roundCtrl.load && roundCtrl.step));

endmodule

/* hdl/aesKeySchedule.sv */
`timescale 1ns/10ps
`include "aes_config.svh"

module aesKeySchedule (
	input  logic               clk,
	input  logic               rstN,
	input  aesPkg::roundCtrl_t roundCtrl,
	input  aesPkg::block_t     cipherKey,
	output aesPkg::block_t     nextRoundKey
);

	aesPkg::block_t roundKey;  // Key of the round last applied.
	aesPkg::byte_t  rcon;      // Constant for the next expansion.
	aesPkg::word_t  rotated;
	aesPkg::word_t  substituted;
	aesPkg::word_t  chain;

	// RotWord then SubWord on the last word of the current key.
	assign rotated = {roundKey[23:0], roundKey[31:24]};

	always_comb begin
		for (int j = 0; j < 4; j++) begin
			substituted[8*j +: 8] = aesPkg::sboxLookup(rotated[8*j +: 8]);
		end
	end

	// Each new word is the old word XOR the new word before it.
	// The first one chains off the substituted word with the round constant.
	always_comb begin
		chain = substituted ^ {rcon, 24'h000000};
		for (int i = 0; i < `AES_KEY_WORDS; i++) begin
			chain = chain ^ roundKey[(`AES_BLOCK_BITS - 1) - 32*i -: 32];
			nextRoundKey[(`AES_BLOCK_BITS - 1) - 32*i -: 32] = chain;
		end
	end

	always_ff @(posedge clk) begin
		if (roundCtrl.load)
			roundKey <= cipherKey;
		else if (roundCtrl.step)
			roundKey <= nextRoundKey;
	end

	// The constant runs 01, 02, 04 ... 80, 1b, 36 over the ten rounds.
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			rcon <= `AES_RCON_INIT;
		else if (roundCtrl.load)
			rcon <= `AES_RCON_INIT;
		else if (roundCtrl.step)
			rcon <= aesPkg::gfDouble(rcon);
	end

	rconNonZero: assert property (@(posedge clk) disable iff (!rstN)
		roundCtrl.step |-> (rcon != '0));

endmodule

/* hdl/aesMixColumns.sv */
`timescale 1ns/10ps

module aesMixColumns (
	input  aesPkg::block_t stateIn,
	output aesPkg::block_t stateOut
);

	localparam int topBit = $bits(aesPkg::block_t) - 1;

	aesPkg::byte_t col [4];
	aesPkg::byte_t dbl [4];

	// Row r of the product is 2*a[r] ^ 3*a[r+1] ^ a[r+2] ^ a[r+3], indices mod 4.
	// With 3*x = 2*x ^ x this reduces to doublings and XORs only.
	always_comb begin
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++) begin
				col[r] = stateIn[topBit - 8*(r + 4*c) -: 8];
				dbl[r] = aesPkg::gfDouble(col[r]);
			end
			for (int r = 0; r < 4; r++) begin
				stateOut[topBit - 8*(r + 4*c) -: 8] = dbl[r] ^ dbl[(r + 1) % 4]
					^ col[(r + 1) % 4] ^ col[(r + 2) % 4] ^ col[(r + 3) % 4];
			end
		end
	end

endmodule

/* hdl/aesRoundDatapath.sv */
`timescale 1ns/10ps

module aesRoundDatapath (
	input  logic               clk,
	input  logic               rstN,
	input  aesPkg::roundCtrl_t roundCtrl,
	input  aesPkg::block_t     plainText,
	input  aesPkg::block_t     cipherKey,
	input  aesPkg::block_t     nextRoundKey,
	output aesPkg::block_t     cipherText
);

	localparam int topBit = $bits(aesPkg::block_t) - 1;

	aesPkg::block_t stateReg;
	aesPkg::block_t subbed;
	aesPkg::block_t shifted;
	aesPkg::block_t mixed;
	aesPkg::block_t roundOut;

	// SubBytes, one table lookup per byte.
	always_comb begin
		for (int k = 0; k < 16; k++) begin
			subbed[8*k +: 8] = aesPkg::sboxLookup(stateReg[8*k +: 8]);
		end
	end

	// Byte k is row k%4 of column k/4, with byte 0 in the top bits.
	// Row r rotates left by r columns.
	always_comb begin
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++) begin
				shifted[topBit - 8*(r + 4*c) -: 8] =
					subbed[topBit - 8*(r + 4*((c + r) % 4)) -: 8];
			end
		end
	end

	aesMixColumns i_mixColumns (
		.stateIn  (shifted),
		.stateOut (mixed)
	);

	// The final round drops MixColumns.
	assign roundOut = (roundCtrl.lastRound ? shifted : mixed) ^ nextRoundKey;

	always_ff @(posedge clk) begin
		if (roundCtrl.load)
			stateReg <= plainText ^ cipherKey;  // Initial AddRoundKey.
		else if (roundCtrl.step)
			stateReg <= roundOut;
	end

	// Holds the last result until the next block finishes.
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN)
			cipherText <= '0;
		else if (roundCtrl.step && roundCtrl.lastRound)
			cipherText <= roundOut;
	end

endmodule

/* hdl/aesEncryptTop.sv */
`timescale 1ns/10ps

module aesEncryptTop (
	input  logic           clk,
	input  logic           rstN,
	input  logic           start,
	input  aesPkg::block_t plainText,
	input  aesPkg::block_t cipherKey,
	output aesPkg::block_t cipherText,
	output logic           done,
	output logic           busy
);

	aesPkg::roundCtrl_t roundCtrl;
	aesPkg::block_t     nextRoundKey;  // Key for the round running this cycle.

	aesControl i_control (
		.clk       (clk),
		.rstN      (rstN),
		.start     (start),
		.roundCtrl (roundCtrl),
		.done      (done),
		.busy      (busy)
	);

	aesKeySchedule i_keySchedule (
		.clk          (clk),
		.rstN         (rstN),
		.roundCtrl    (roundCtrl),
		.cipherKey    (cipherKey),
		.nextRoundKey (nextRoundKey)
	);

	aesRoundDatapath i_datapath (
		.clk          (clk),
		.rstN         (rstN),
		.roundCtrl    (roundCtrl),
		.plainText    (plainText),
		.cipherKey    (cipherKey),
		.nextRoundKey (nextRoundKey),
		.cipherText   (cipherText)
	);

endmodule

/* sim/tbClockGen.sv */
`timescale 1ns/10ps

module tbClockGen #(
	parameter int periodNs    = 10,
	parameter int resetCycles = 16
) (
	output logic clk,
	output logic rstN
);

	initial begin
		clk = 1'b0;
		forever #(periodNs / 2) clk = ~clk;
	end

	// Reset is released on a rising edge, like every other driven input.
	initial begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		rstN <= 1'b1;
	end

endmodule

/* sim/tbAesEncrypt.sv */
`timescale 1ns/10ps
`include "aes_config.svh"

module tbAesEncrypt;

	localparam int periodNs       = 10;
	localparam int resetCycles    = 16;
	localparam int katCount       = 3;
	localparam int cyclesPerTest  = 12;
	localparam int holdCycles     = 6;
	localparam int blockLimit     = 2 * `AES_ROUNDS;  // Give up on done after this many edges.
	localparam int watchdogCycles = (katCount + 4) * cyclesPerTest + resetCycles;

	typedef struct packed {
		aesPkg::block_t plain;
		aesPkg::block_t key;
		aesPkg::block_t cipher;
	} knownAnswer_t;

	logic           clk;
	logic           rstN;
	logic           start;
	aesPkg::block_t plainText;
	aesPkg::block_t cipherKey;
	aesPkg::block_t cipherText;
	logic           done;
	logic           busy;

	knownAnswer_t katTable [katCount];
	string        katNames [katCount];

	string testName;
	int    testErrors;
	int    passCount;
	int    failCount;

	tbClockGen #(
		.periodNs    (periodNs),
		.resetCycles (resetCycles)
	) i_clockGen (
		.clk  (clk),
		.rstN (rstN)
	);

	aesEncryptTop i_dut (
		.clk        (clk),
		.rstN       (rstN),
		.start      (start),
		.plainText  (plainText),
		.cipherKey  (cipherKey),
		.cipherText (cipherText),
		.done       (done),
		.busy       (busy)
	);

	// Published vectors from FIPS-197 plus the well known all-zero case.
	task automatic fillTable();
		katNames[0] = "fips197 appendix B";
		katTable[0] = '{plain:  128'h3243f6a8885a308d313198a2e0370734,
		                key:    128'h2b7e151628aed2a6abf7158809cf4f3c,
		                cipher: 128'h3925841d02dc09fbdc118597196a0b32};
		katNames[1] = "fips197 appendix C.1";
		katTable[1] = '{plain:  128'h00112233445566778899aabbccddeeff,
		                key:    128'h000102030405060708090a0b0c0d0e0f,
		                cipher: 128'h69c4e0d86a7b0430d8cdb78070b4c55a};
		katNames[2] = "all zero";
		katTable[2] = '{plain:  128'h0,
		                key:    128'h0,
		                cipher: 128'h66e94bd4ef8a2c3b884cfa59ca342b2e};
	endtask

	task automatic beginTest(input string name);
		testName   = name;
		testErrors = 0;
	endtask

	task automatic endTest();
		if (testErrors == 0) begin
			passCount++;
			$display("Test %s passed", testName);
		end else begin
			failCount++;
			$display("Test %s failed with %0d errors", testName, testErrors);
		end
	endtask

	task automatic checkBlock(input string what, input aesPkg::block_t expected,
		input aesPkg::block_t actual);
		assert (actual === expected) else begin
			$display("Error in %s: %s expected %h actual %h", testName, what, expected, actual);
			testErrors++;
		end
	endtask

	task automatic checkLevel(input string what, input logic expected, input logic actual);
		assert (actual === expected) else begin
			$display("Error in %s: %s expected %b actual %b", testName, what, expected, actual);
			testErrors++;
		end
	endtask

	task automatic checkCount(input string what, input int expected, input int actual);
		assert (actual == expected) else begin
			$display("Error in %s: %s expected %0d actual %0d", testName, what, expected, actual);
			testErrors++;
		end
	endtask

	task automatic driveStart(input aesPkg::block_t pt, input aesPkg::block_t key);
		start     <= 1'b1;
		plainText <= pt;
		cipherKey <= key;
	endtask

	// Returns in the time step of the edge that accepts the block.
	task automatic launchBlock(input aesPkg::block_t pt, input aesPkg::block_t key);
		@(posedge clk);
		driveStart(pt, key);
		#1;
		checkLevel("done one cycle after its pulse", 1'b0, done);
		@(posedge clk);
		start <= 1'b0;
	endtask

	// Counts edges after the accepting edge until done shows. A second start can be
	// driven at edge injectAt, which is how the busy and chaining cases are made.
	task automatic followBlock(input int injectAt, input aesPkg::block_t injPt,
		input aesPkg::block_t injKey, output int latency, output bit busyHeld);
		latency  = 0;
		busyHeld = 1'b1;
		#1;
		checkLevel("busy after the accepting edge", 1'b1, busy);
		checkLevel("done after the accepting edge", 1'b0, done);
		while (!done && latency < blockLimit) begin
			if (!busy)
				busyHeld = 1'b0;
			@(posedge clk);
			latency++;
			if (injectAt > 0 && latency == injectAt)
				driveStart(injPt, injKey);
			else if (injectAt > 0 && latency == injectAt + 1)
				start <= 1'b0;
			#1;
		end
		assert (done) else begin
			$display("%s: done never pulsed within %0d cycles of start.", testName, blockLimit);
			testErrors++;
		end
	endtask

	task automatic checkResult(input aesPkg::block_t expected, input int latency,
		input bit busyHeld);
		checkCount("cycles from start to done", `AES_ROUNDS, latency);
		checkLevel("busy through the block", 1'b1, busyHeld);
		checkLevel("busy after done", 1'b0, busy);
		checkBlock("cipherText", expected, cipherText);
	endtask

	initial begin
		int latency;
		bit busyHeld;

		start     = 1'b0;
		plainText = '0;
		cipherKey = '0;
		passCount = 0;
		failCount = 0;
		fillTable();

		wait (rstN === 1'b1);
		#1;
		beginTest("reset state");
		checkLevel("done", 1'b0, done);
		checkLevel("busy", 1'b0, busy);
		checkBlock("cipherText", '0, cipherText);
		endTest();

		for (int i = 0; i < katCount; i++) begin
			beginTest(katNames[i]);
			launchBlock(katTable[i].plain, katTable[i].key);
			followBlock(0, '0, '0, latency, busyHeld);
			checkResult(katTable[i].cipher, latency, busyHeld);
			endTest();
		end

		// The stray start comes during round 5 with other data and another key.
		beginTest("start while busy");
		launchBlock(katTable[0].plain, katTable[0].key);
		followBlock(4, katTable[1].plain, katTable[1].key, latency, busyHeld);
		checkResult(katTable[0].cipher, latency, busyHeld);
		endTest();

		// Idle cycles also catch a late done from the stray start.
		beginTest("output hold");
		repeat (holdCycles) begin
			@(posedge clk);
			#1;
			checkLevel("done while idle", 1'b0, done);
			checkLevel("busy while idle", 1'b0, busy);
			checkBlock("cipherText while idle", katTable[0].cipher, cipherText);
		end
		endTest();

		beginTest("back to back");
		launchBlock(katTable[1].plain, katTable[1].key);
		followBlock(`AES_ROUNDS, katTable[2].plain, katTable[2].key, latency, busyHeld);
		checkResult(katTable[1].cipher, latency, busyHeld);
		@(posedge clk);
		start <= 1'b0;  // The second block is accepted on this edge.
		followBlock(0, '0, '0, latency, busyHeld);
		checkResult(katTable[2].cipher, latency, busyHeld);
		@(posedge clk);
		#1;
		checkLevel("done one cycle after its pulse", 1'b0, done);
		endTest();

		$display("Tests passed: %0d, failed: %0d", passCount, failCount);
		if (failCount == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	initial begin
		#(watchdogCycles * periodNs);
		$display("Watchdog expired after %0d cycles with tests still running.", watchdogCycles);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* src.f */
+incdir+hdl
hdl/aesPkg.sv
hdl/aesControl.sv
hdl/aesKeySchedule.sv
hdl/aesMixColumns.sv
hdl/aesRoundDatapath.sv
hdl/aesEncryptTop.sv
sim/tbClockGen.sv
sim/tbAesEncrypt.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it, and searches the log for the fail message.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tbAesEncrypt -f src.f -o simAes > build.log 2>&1 \
	|| { cat build.log; echo "Verilator build failed."; exit 1; }
./obj_dir/simAes > sim.log 2>&1
cat sim.log
grep -q "STATUS: FAIL" sim.log && { echo "Simulation reported failure."; exit 1; }
grep -q "STATUS: PASS" sim.log || { echo "Simulation ended without a result."; exit 1; }
exit 0
